// File: tb/aesCases.txt
# AES-128 known-answer vectors, one case per line
# key plaintext expected_ciphertext, all 128-bit hex
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
00000000000000000000000000000000 9798c4640bad75c7c3227db910174e72 a9a1631bf4996954ebc093957b234589
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688

// File: aesCore.f
hdl/aesStatePkg.sv
hdl/aesFieldPkg.sv
hdl/sboxRom.sv
hdl/aesControl.sv
hdl/aesKeyExpander.sv
hdl/aesRoundPath.sv
hdl/aesTop.sv
tb/aesTopTb.sv

// File: Bender.yml
package:
  name: aesCore

sources:
  # Packages first, the field package imports the state package
  - hdl/aesStatePkg.sv
  - hdl/aesFieldPkg.sv
  # Leaf modules, then the top level
  - hdl/sboxRom.sv
  - hdl/aesControl.sv
  - hdl/aesKeyExpander.sv
  - hdl/aesRoundPath.sv
  - hdl/aesTop.sv
  # Simulation only
  - target: test
    files:
      - tb/aesTopTb.sv

// File: tb/aesTopTb.sv
// AES-128 core testbench
// Runs known-answer vectors from the cases file through the core
// Checks results, latency, done pulse width, ignored loads and result hold

`timescale 1ns/1ps
`default_nettype none

module aesTopTb
  import aesStatePkg::*;
();

  localparam int    ClockPeriod = 10;
  localparam int    ResetCycles = 8;
  // Capture edge to round ten update edge
  localparam int    RunCycles   = 2 * NumRounds;
  // Edge where a load is driven in the middle of a run
  localparam int    DecoyEdge   = 8;
  // Per-run and per-case watchdog budget
  localparam int    CaseLimit   = 40;
  localparam string CasesFile   = "tb/aesCases.txt";

  logic    clk = 1'b0;
  logic    reset;
  logic    load;
  aesBlock key;
  aesBlock plaintext;
  aesBlock ciphertext;
  logic    busy;
  logic    done;

  // Vectors from the cases file
  logic [127:0] caseKeys[$];
  logic [127:0] casePlain[$];
  logic [127:0] caseCipher[$];
  int           numCases    = 0;
  bit           casesLoaded = 1'b0;
  int           errorCount  = 0;

  // Decoy generator state
  logic [31:0]  lfsrState   = 32'd73;

  always #(ClockPeriod / 2) clk = ~clk;

  aesTop i_dut (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .key        (key),
    .plaintext  (plaintext),
    .ciphertext (ciphertext),
    .busy       (busy),
    .done       (done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(logic [31:0] value);
    return value[0] ? ((value >> 1) ^ 32'h80200003) : (value >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [127:0] randomBlock();
    logic [127:0] bits;
    for (int i = 0; i < 128; i++) begin
      lfsrState = lfsrStep(lfsrState);
      bits[i]   = lfsrState[0];
    end
    return bits;
  endfunction

  task automatic stopRun(string reason);
    errorCount++;
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic checkValue(string name, logic [127:0] expected, logic [127:0] actual);
    if (actual !== expected) begin
      stopRun($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // Lines hold key, plaintext and ciphertext in hex, # starts a comment
  task automatic loadCases();
    int           fd;
    int           count;
    string        line;
    logic [127:0] k;
    logic [127:0] p;
    logic [127:0] c;
    fd = $fopen(CasesFile, "r");
    if (fd == 0) begin
      stopRun({"Could not open the vector file ", CasesFile});
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 2 && line[0] != "#") begin
        count = $sscanf(line, "%h %h %h", k, p, c);
        if (count != 3) begin
          stopRun({"Malformed line in the vector file: ", line});
        end
        caseKeys.push_back(k);
        casePlain.push_back(p);
        caseCipher.push_back(c);
      end
    end
    $fclose(fd);
    numCases = caseKeys.size();
    if (numCases == 0) begin
      stopRun("The vector file holds no cases");
    end
    casesLoaded = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One encryption run
  ////////////////////////////////////////////////////////////////////////////

  task automatic runCase(int idx, bit checkHold, logic [127:0] heldCipher);
    int    edgeCount;
    string name;
    name = $sformatf("case %0d", idx);
    // Load is high for one cycle, the next edge captures it
    @(posedge clk);
    load      <= 1'b1;
    key       <= caseKeys[idx];
    plaintext <= casePlain[idx];
    @(negedge clk);
    // Previous result holds until this load is captured
    if (checkHold) begin
      checkValue({name, " held ciphertext"}, heldCipher, ciphertext);
      checkValue({name, " done width"}, 1'b0, done);
    end
    checkValue({name, " busy before load"}, 1'b0, busy);
    // Edge 0 is the capture edge
    edgeCount = -1;
    do begin
      @(posedge clk);
      edgeCount++;
      // Load mid-run must be ignored
      if (edgeCount == DecoyEdge) begin
        load <= 1'b1;
      end else begin
        load <= 1'b0;
      end
      // Noise on the data inputs after capture
      key       <= randomBlock();
      plaintext <= randomBlock();
      @(negedge clk);
      if (edgeCount > CaseLimit) begin
        stopRun({"Timeout: done never pulsed in ", name});
      end
      if (!done) begin
        checkValue({name, " busy during run"}, 1'b1, busy);
      end
    end while (!done);
    checkValue({name, " latency"}, RunCycles, edgeCount);
    checkValue({name, " busy at done"}, 1'b0, busy);
    checkValue({name, " ciphertext"}, caseCipher[idx], ciphertext);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [127:0] lastCipher;
    reset      = 1'b1;
    load       = 1'b0;
    key        = '0;
    plaintext  = '0;
    lastCipher = '0;
    loadCases();
    // Outputs stay low through reset
    for (int i = 0; i < ResetCycles; i++) begin
      @(posedge clk);
      if (i == ResetCycles - 1) begin
        reset <= 1'b0;
      end
      @(negedge clk);
      checkValue("busy in reset", 1'b0, busy);
      checkValue("done in reset", 1'b0, done);
    end
    @(posedge clk);
    @(negedge clk);
    checkValue("busy after reset", 1'b0, busy);
    checkValue("done after reset", 1'b0, done);
    // Each next load follows right after done
    for (int i = 0; i < numCases; i++) begin
      runCase(i, i > 0, lastCipher);
      lastCipher = caseCipher[i];
    end
    // Last done pulse ends after one cycle
    @(negedge clk);
    checkValue("final done width", 1'b0, done);
    checkValue("final held ciphertext", lastCipher, ciphertext);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Budget scales with the number of cases
  initial begin
    wait (casesLoaded);
    repeat (numCases * CaseLimit + 200) @(posedge clk);
    stopRun("Timeout: the run did not finish within its cycle budget");
  end

endmodule

`default_nettype wire

// File: hdl/aesTop.sv
// AES-128 encryption core
// Load pulse in, ciphertext and done pulse out after twenty cycles

`timescale 1ns/1ps
`default_nettype none

module aesTop
  import aesStatePkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    load,
  input  aesBlock key,
  input  aesBlock plaintext,
  output aesBlock ciphertext,
  output logic    busy,
  output logic    done
);

  // Shared by both datapaths, keeps them in lock-step
  aesCtrl  ctrl;
  // Next round key into the state path
  aesBlock roundKey;

  aesControl controller (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .ctrl  (ctrl),
    .busy  (busy),
    .done  (done)
  );

  aesKeyExpander keyPath (
    .clk      (clk),
    .key      (key),
    .ctrl     (ctrl),
    .roundKey (roundKey)
  );

  // State register doubles as the ciphertext hold
  aesRoundPath statePath (
    .clk       (clk),
    .key       (key),
    .plaintext (plaintext),
    .ctrl      (ctrl),
    .roundKey  (roundKey),
    .state     (ciphertext)
  );

endmodule

`default_nettype wire

// File: hdl/aesRoundPath.sv
// AES-128 round datapath
// State register with sixteen S-box lanes, shift rows, mix columns and key add

`timescale 1ns/1ps
`default_nettype none

module aesRoundPath
  import aesStatePkg::*, aesFieldPkg::*;
(
  input  logic    clk,
  input  aesBlock key,
  input  aesBlock plaintext,
  input  aesCtrl  ctrl,
  input  aesBlock roundKey,
  output aesBlock state
);

  // Registered SubBytes result
  aesBlock subState;
  aesBlock shifted;
  aesBlock mixed;
  aesBlock nextState;

  ////////////////////////////////////////////////////////////////////////////
  // SubBytes
  ////////////////////////////////////////////////////////////////////////////

  // One lane per state byte
  // Lane g serves column g/4, row g%4
  for (genvar g = 0; g < 16; g++) begin : stateLane
    sboxRom lane (
      .clk  (clk),
      .addr (state[g/4][g%4]),
      .data (subState[g/4][g%4])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // ShiftRows, MixColumns, AddRoundKey
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    shifted = shiftRows(subState);
    for (int c = 0; c < 4; c++) begin
      mixed[c] = mixColumn(shifted[c]);
    end
    // Final round has no column mixing
    nextState = (ctrl.lastRound ? shifted : mixed) ^ roundKey;
  end

  // Initial key addition on load
  // One full round per update edge after that
  always_ff @(posedge clk) begin
    if (ctrl.start) begin
      state <= plaintext ^ key;
    end else if (isUpdate(ctrl)) begin
      state <= nextState;
    end
  end

  // State moves only on a load or right after a substitution cycle
  assert property (@(posedge clk)
    (!ctrl.start && !$past(ctrl.subPhase) && !$isunknown(state)) |=> $stable(state));

endmodule

`default_nettype wire

// File: hdl/aesKeyExpander.sv
// AES-128 key schedule
// Holds the current round key and forms the next one with four S-box lanes

`timescale 1ns/1ps
`default_nettype none

module aesKeyExpander
  import aesStatePkg::*, aesFieldPkg::*;
(
  input  logic    clk,
  input  aesBlock key,
  input  aesCtrl  ctrl,
  output aesBlock roundKey
);

  // Round key of the previous round
  aesBlock keyReg;
  // RotWord of the last column
  aesWord  rotWord;
  // Registered SubWord, valid on the update cycle
  aesWord  subWord;
  aesByte  rconByte;

  ////////////////////////////////////////////////////////////////////////////
  // RotWord and SubWord
  ////////////////////////////////////////////////////////////////////////////

  // Rotate bytes up by one row
  assign rotWord = {keyReg[3][1], keyReg[3][2], keyReg[3][3], keyReg[3][0]};

  for (genvar i = 0; i < 4; i++) begin : keyLane
    sboxRom lane (
      .clk  (clk),
      .addr (rotWord[i]),
      .data (subWord[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next round key
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // No constant outside a run
    rconByte = (ctrl.roundIndex inside {[1:NumRounds]}) ? RconTable[ctrl.roundIndex] : '0;
    roundKey[0] = keyReg[0] ^ subWord ^ {rconByte, 24'h000000};
    // Each later column folds in the one before it
    for (int w = 1; w < 4; w++) begin
      roundKey[w] = roundKey[w-1] ^ keyReg[w];
    end
  end

  // Cipher key on load, then one step per round
  always_ff @(posedge clk) begin
    if (ctrl.start) begin
      keyReg <= key;
    end else if (isUpdate(ctrl)) begin
      keyReg <= roundKey;
    end
  end

  // Key must hold while its lanes are substituting
  assert property (@(posedge clk)
    (ctrl.subPhase && !$isunknown(keyReg)) |=> $stable(keyReg));

endmodule

`default_nettype wire

// File: hdl/aesControl.sv
// AES round sequencer
// Steps ten rounds of substitute then update, drives busy and the done pulse

`timescale 1ns/1ps
`default_nettype none

module aesControl
  import aesStatePkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   load,
  output aesCtrl ctrl,
  output logic   busy,
  output logic   done
);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer registers
  ////////////////////////////////////////////////////////////////////////////

  // Run flag
  logic running;
  // High on the substitution half of a round
  logic phase;
  // Zero while idle
  logic [RoundIndexWidth-1:0] roundIndex;

  // Load is taken only while idle
  assign ctrl.start      = load && !running;
  assign ctrl.subPhase   = phase;
  assign ctrl.lastRound  = (roundIndex == NumRounds);
  assign ctrl.roundIndex = roundIndex;

  assign busy = running;

  always_ff @(posedge clk) begin
    if (reset) begin
      running    <= 1'b0;
      phase      <= 1'b0;
      roundIndex <= '0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      if (ctrl.start) begin
        // Capture edge, round 1 opens with substitution
        running    <= 1'b1;
        phase      <= 1'b1;
        roundIndex <= RoundIndexWidth'(1);
      end else if (running) begin
        if (phase) begin
          phase <= 1'b0;
        end else if (ctrl.lastRound) begin
          // Round ten update edge
          running    <= 1'b0;
          roundIndex <= '0;
          done       <= 1'b1;
        end else begin
          phase      <= 1'b1;
          roundIndex <= roundIndex + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Done follows an update edge, never a substitution cycle
  assert property (@(posedge clk) disable iff (reset)
    done |-> !ctrl.subPhase);

  // Counter stays in range for the whole run
  assert property (@(posedge clk) disable iff (reset)
    busy |-> (roundIndex inside {[1:NumRounds]}));

  // A load during a run never reopens round 1
  assert property (@(posedge clk) disable iff (reset)
    (busy && load) |=> !(ctrl.subPhase && ctrl.roundIndex == 1));

endmodule

`default_nettype wire

// File: hdl/sboxRom.sv
// Synchronous S-box lane
// One byte substitution per clock, registered so the table can sit in block RAM

`timescale 1ns/1ps
`default_nettype none

module sboxRom
  import aesStatePkg::*, aesFieldPkg::*;
(
  input  logic   clk,
  input  aesByte addr,
  output aesByte data
);

  // Table copy as an inferable ROM
  aesByte rom [0:255];

  initial begin
    for (int i = 0; i < 256; i++) begin
      rom[i] = SboxTable[i];
    end
  end

  // Free-running lookup
  // Callers sample it on the cycle their phase needs
  always_ff @(posedge clk) begin
    data <= rom[addr];
  end

endmodule

`default_nettype wire

// File: hdl/aesFieldPkg.sv
// AES-128 field arithmetic and lookup tables
// GF(2^8) multiply by x, column mixing, row shifting, S-box and round constants

`default_nettype none

package aesFieldPkg;

  import aesStatePkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup tables
  ////////////////////////////////////////////////////////////////////////////

  // FIPS-197 S-box
  // Entry 0 is the leftmost byte of the concatenation
  localparam aesByte [0:255] SboxTable = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // Round constants, first byte of rcon[i]
  // Indexed directly by round number 1 to 10
  localparam aesByte [1:10] RconTable = {
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
    8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
  };

  ////////////////////////////////////////////////////////////////////////////
  // Field operations
  ////////////////////////////////////////////////////////////////////////////

  // Multiply by x
  // Left shift, fold the carry back with x^8 = x^4 + x^3 + x + 1
  function automatic aesByte xtime(aesByte value);
    return {value[6:0], 1'b0} ^ (value[7] ? 8'h1b : 8'h00);
  endfunction

  // Mix one column with xtime only
  // y[r] = a[r] ^ (a0^a1^a2^a3) ^ 2*(a[r]^a[r+1])
  function automatic aesWord mixColumn(aesWord col);
    aesByte total;
    aesWord result;
    total = col[0] ^ col[1] ^ col[2] ^ col[3];
    for (int r = 0; r < 4; r++) begin
      result[r] = col[r] ^ total ^ xtime(col[r] ^ col[(r + 1) % 4]);
    end
    return result;
  endfunction

  // Row r rotates left by r columns
  function automatic aesBlock shiftRows(aesBlock blk);
    aesBlock result;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        result[c][r] = blk[(c + r) % 4][r];
      end
    end
    return result;
  endfunction

endpackage

`default_nettype wire

// File: hdl/aesStatePkg.sv
// AES-128 state and sequencing types
// Byte, column and block layout plus the control word shared by the datapaths

`default_nettype none

package aesStatePkg;

  // One state or key byte
  typedef logic [7:0] aesByte;

  // One column of four bytes
  // Element 0 sits in the top byte and holds row 0
  typedef aesByte [0:3] aesWord;

  // Full 128-bit state or round key
  // Word 0 is the top 32 bits, so blk[c][r] is byte index 4*c + r
  typedef aesWord [0:3] aesBlock;

  // Full rounds after the initial key addition
  localparam int unsigned NumRounds = 10;

  // Round counter holds 0 when idle, 1 to NumRounds while running
  localparam int unsigned RoundIndexWidth = 4;

  // Control word from the sequencer, seven bits
  typedef struct packed {
    // Accepted load, high in the cycle before the capture edge
    logic start;
    // Substitution cycle of a round
    logic subPhase;
    // Final round, mix columns skipped
    logic lastRound;
    // Current round number
    logic [RoundIndexWidth-1:0] roundIndex;
  } aesCtrl;

  // Update cycle of a round
  // Needs a live round index since the phase bit is low while idle
  function automatic logic isUpdate(aesCtrl ctrl);
    return !ctrl.subPhase && (ctrl.roundIndex != '0);
  endfunction

endpackage

`default_nettype wire
